//--- verilog/alu_pkg.sv
`default_nettype none

package alu_pkg;

  localparam int xlen = 32;                   // datapath width
  localparam int shamt_w = $clog2(xlen);      // shift amount bits taken from src2

  // divider timing
  localparam int div_iters = 32;              // one quotient bit per run cycle
  localparam int div_cnt_w = $clog2(div_iters);
  localparam int div_stall_cycles = 34;       // start + run + done, miss case

  localparam int cache_entries = 2;           // divide history depth

  typedef enum logic [4:0] {
    op_add,
    op_sub,
    op_slt,
    op_sltu,
    op_and,
    op_nor,
    op_or,
    op_xor,
    op_sll,
    op_srl,
    op_sra,
    op_lui,
    op_mul,    // low word
    op_mulh,   // signed high word
    op_mulhu,  // unsigned high word
    op_div,
    op_divu,
    op_mod,
    op_modu
  } alu_op_e;

  typedef enum logic [1:0] {
    div_idle,
    div_run,
    div_done
  } div_state_e;

endpackage

`default_nettype wire

//--- verilog/mult_core.sv
`timescale 1ns/10ps
`default_nettype none

module mult_core (
  input  wire                          clk,
  input  wire                          rstn,
  input  wire  [alu_pkg::xlen-1:0]     src1,
  input  wire  [alu_pkg::xlen-1:0]     src2,
  input  wire                          sign_en,
  output logic [2*alu_pkg::xlen-1:0]   product
);

  // one extra bit so signed and unsigned share a single signed multiplier
  logic signed [alu_pkg::xlen:0]       a_ext;
  logic signed [alu_pkg::xlen:0]       b_ext;
  logic signed [2*alu_pkg::xlen+1:0]   full_prod;

  assign a_ext = {sign_en & src1[alu_pkg::xlen-1], src1};
  assign b_ext = {sign_en & src2[alu_pkg::xlen-1], src2};

  assign full_prod = a_ext * b_ext;

  // product shows up one cycle after the operands
  always_ff @(posedge clk) begin
    if (!rstn) begin
      product <= '0;
    end else begin
      product <= full_prod[2*alu_pkg::xlen-1:0];  // top two bits are sign copies
    end
  end

endmodule

`default_nettype wire

//--- verilog/div_core.sv
`timescale 1ns/10ps
`default_nettype none

module div_core (
  input  wire                      clk,
  input  wire                      rstn,
  input  wire                      start,
  input  wire                      sign_en,
  input  wire  [alu_pkg::xlen-1:0] src1,
  input  wire  [alu_pkg::xlen-1:0] src2,
  output logic [alu_pkg::xlen-1:0] quo,
  output logic [alu_pkg::xlen-1:0] rem,
  output logic                     busy,
  output logic                     done
);

  alu_pkg::div_state_e state;
  logic [alu_pkg::div_cnt_w-1:0] cnt;

  logic [alu_pkg::xlen-1:0] dvd_q;      // dividend magnitude shifted out msb first
  logic [alu_pkg::xlen-1:0] dvs_q;      // divisor magnitude
  logic [alu_pkg::xlen-1:0] prem_q;     // partial remainder
  logic [alu_pkg::xlen-1:0] q_q;        // quotient bits so far
  logic                     quo_neg_q;
  logic                     rem_neg_q;

  logic [alu_pkg::xlen-1:0] src1_mag;
  logic [alu_pkg::xlen-1:0] src2_mag;
  logic [alu_pkg::xlen:0]   prem_shift;
  logic [alu_pkg::xlen:0]   trial;

  assign src1_mag = (sign_en && src1[alu_pkg::xlen-1]) ? -src1 : src1;
  assign src2_mag = (sign_en && src2[alu_pkg::xlen-1]) ? -src2 : src2;

  // bring in next dividend bit, then try the subtract
  assign prem_shift = {prem_q, dvd_q[alu_pkg::xlen-1]};
  assign trial      = prem_shift - {1'b0, dvs_q};

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state <= alu_pkg::div_idle;
      cnt   <= '0;
    end else begin
      case (state)
        alu_pkg::div_idle: begin
          if (start) begin
            state <= alu_pkg::div_run;
            cnt   <= '0;
          end
        end
        alu_pkg::div_run: begin
          cnt <= cnt + 1'b1;
          if (int'(cnt) == alu_pkg::div_iters - 1) begin
            state <= alu_pkg::div_done;
          end
        end
        alu_pkg::div_done: state <= alu_pkg::div_idle;  // single cycle
        default:           state <= alu_pkg::div_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == alu_pkg::div_idle && start) begin
      dvd_q     <= src1_mag;
      dvs_q     <= src2_mag;
      prem_q    <= '0;
      q_q       <= '0;
      quo_neg_q <= sign_en & (src1[alu_pkg::xlen-1] ^ src2[alu_pkg::xlen-1]);
      rem_neg_q <= sign_en & src1[alu_pkg::xlen-1];  // remainder follows dividend
    end else if (state == alu_pkg::div_run) begin
      dvd_q <= dvd_q << 1;
      if (!trial[alu_pkg::xlen]) begin      // divisor fits when there is no borrow
        prem_q <= trial[alu_pkg::xlen-1:0];
        q_q    <= {q_q[alu_pkg::xlen-2:0], 1'b1};
      end else begin
        prem_q <= prem_shift[alu_pkg::xlen-1:0];
        q_q    <= {q_q[alu_pkg::xlen-2:0], 1'b0};
      end
    end
  end

  // sign fix-up is only used while done is high
  assign quo  = quo_neg_q ? -q_q : q_q;
  assign rem  = rem_neg_q ? -prem_q : prem_q;
  assign busy = (state != alu_pkg::div_idle);
  assign done = (state == alu_pkg::div_done);

  // done comes after the full run, lasts one cycle, then back to idle
  a_done_pulse: assert property (@(posedge clk) disable iff (!rstn)
    (state == alu_pkg::div_idle && start) |->
      ##(alu_pkg::div_iters + 1) done ##1 (state == alu_pkg::div_idle));

endmodule

`default_nettype wire

//--- verilog/div_result_cache.sv
`timescale 1ns/10ps
`default_nettype none

module div_result_cache (
  input  wire                      clk,
  input  wire                      rstn,
  input  wire  [alu_pkg::xlen-1:0] src1,
  input  wire  [alu_pkg::xlen-1:0] src2,
  input  wire                      sign_en,
  input  wire                      write,
  input  wire  [alu_pkg::xlen-1:0] wr_quo,
  input  wire  [alu_pkg::xlen-1:0] wr_rem,
  output logic                     hit,
  output logic [alu_pkg::xlen-1:0] hit_quo,
  output logic [alu_pkg::xlen-1:0] hit_rem
);

  logic [alu_pkg::cache_entries-1:0] valid_q;
  logic [alu_pkg::xlen-1:0]          op1_q  [alu_pkg::cache_entries];
  logic [alu_pkg::xlen-1:0]          op2_q  [alu_pkg::cache_entries];
  logic                              sign_q [alu_pkg::cache_entries];
  logic [alu_pkg::xlen-1:0]          quo_q  [alu_pkg::cache_entries];
  logic [alu_pkg::xlen-1:0]          rem_q  [alu_pkg::cache_entries];

  logic [$clog2(alu_pkg::cache_entries)-1:0] wr_ptr;  // oldest entry
  logic [alu_pkg::cache_entries-1:0]         match;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      valid_q <= '0;
      wr_ptr  <= '0;
    end else if (write) begin
      valid_q[wr_ptr] <= 1'b1;
      wr_ptr          <= wr_ptr + 1'b1;  // round robin
    end
  end

  always_ff @(posedge clk) begin
    if (write) begin
      op1_q[wr_ptr]  <= src1;
      op2_q[wr_ptr]  <= src2;
      sign_q[wr_ptr] <= sign_en;
      quo_q[wr_ptr]  <= wr_quo;
      rem_q[wr_ptr]  <= wr_rem;
    end
  end

  for (genvar i = 0; i < alu_pkg::cache_entries; i++) begin : g_match
    assign match[i] = valid_q[i] && (op1_q[i] == src1) && (op2_q[i] == src2)
                      && (sign_q[i] == sign_en);
  end

  assign hit = |match;

  // walk down so the lowest matching entry wins
  always_comb begin
    hit_quo = '0;
    hit_rem = '0;
    for (int i = alu_pkg::cache_entries - 1; i >= 0; i--) begin
      if (match[i]) begin
        hit_quo = quo_q[i];
        hit_rem = rem_q[i];
      end
    end
  end

  a_match_agree: assert property (@(posedge clk) disable iff (!rstn)
    (&match) |-> (quo_q[0] == quo_q[1]) && (rem_q[0] == rem_q[1]));

endmodule

`default_nettype wire

//--- verilog/alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu (
  input  wire                      clk,
  input  wire                      rstn,
  input  wire alu_pkg::alu_op_e    alu_op,
  input  wire  [alu_pkg::xlen-1:0] src1,
  input  wire  [alu_pkg::xlen-1:0] src2,
  output logic [alu_pkg::xlen-1:0] result,
  output logic                     stall
);

  logic                         adder_inv;
  logic [alu_pkg::xlen-1:0]     adder_b;
  logic [alu_pkg::xlen-1:0]     adder_sum;
  logic                         adder_cout;
  logic                         slt_bit;
  logic                         sltu_bit;
  logic [alu_pkg::xlen-1:0]     sll_res;
  logic                         sra_fill;
  logic [2*alu_pkg::xlen-1:0]   sr64_res;

  logic                         is_mul;
  logic                         mul_sign;
  logic [2*alu_pkg::xlen-1:0]   product;
  logic                         mult_stall;
  logic                         mult_stall_q;

  logic                         is_div;
  logic                         div_sign;
  logic                         div_by_zero;
  logic                         div_of_zero;
  logic                         div_miss;
  logic                         div_start;
  logic                         div_busy;
  logic                         div_done;
  logic [alu_pkg::xlen-1:0]     div_quo;
  logic [alu_pkg::xlen-1:0]     div_rem;
  logic                         cache_hit;
  logic [alu_pkg::xlen-1:0]     hit_quo;
  logic [alu_pkg::xlen-1:0]     hit_rem;
  logic [alu_pkg::xlen-1:0]     quo_res;
  logic [alu_pkg::xlen-1:0]     rem_res;

  // shared adder computes src1 - src2 for sub and compares
  assign adder_inv = alu_op inside {alu_pkg::op_sub, alu_pkg::op_slt, alu_pkg::op_sltu};
  assign adder_b   = adder_inv ? ~src2 : src2;
  assign {adder_cout, adder_sum} = {1'b0, src1} + {1'b0, adder_b}
                                   + {{alu_pkg::xlen{1'b0}}, adder_inv};

  assign slt_bit  = (src1[alu_pkg::xlen-1] & ~src2[alu_pkg::xlen-1])
                  | ((src1[alu_pkg::xlen-1] ~^ src2[alu_pkg::xlen-1])
                     & adder_sum[alu_pkg::xlen-1]);
  assign sltu_bit = ~adder_cout;  // borrow out

  assign sll_res  = src1 << src2[alu_pkg::shamt_w-1:0];
  assign sra_fill = (alu_op == alu_pkg::op_sra) & src1[alu_pkg::xlen-1];
  assign sr64_res = {{alu_pkg::xlen{sra_fill}}, src1} >> src2[alu_pkg::shamt_w-1:0];

  assign is_mul   = alu_op inside {alu_pkg::op_mul, alu_pkg::op_mulh, alu_pkg::op_mulhu};
  assign mul_sign = alu_op inside {alu_pkg::op_mul, alu_pkg::op_mulh};

  mult_core mult_inst (
    .clk     (clk),
    .rstn    (rstn),
    .src1    (src1),
    .src2    (src2),
    .sign_en (mul_sign),
    .product (product)
  );

  // stall toggles so a held multiply restarts the pair
  assign mult_stall = is_mul ^ mult_stall_q;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      mult_stall_q <= 1'b0;
    end else begin
      mult_stall_q <= mult_stall;
    end
  end

  assign is_div      = alu_op inside {alu_pkg::op_div, alu_pkg::op_divu,
                                      alu_pkg::op_mod, alu_pkg::op_modu};
  assign div_sign    = alu_op inside {alu_pkg::op_div, alu_pkg::op_mod};
  assign div_by_zero = (src2 == '0);
  assign div_of_zero = (src1 == '0);
  assign div_miss    = is_div & ~div_by_zero & ~div_of_zero & ~cache_hit;
  assign div_start   = div_miss & ~div_busy;

  div_core div_inst (
    .clk     (clk),
    .rstn    (rstn),
    .start   (div_start),
    .sign_en (div_sign),
    .src1    (src1),
    .src2    (src2),
    .quo     (div_quo),
    .rem     (div_rem),
    .busy    (div_busy),
    .done    (div_done)
  );

  div_result_cache cache_inst (
    .clk     (clk),
    .rstn    (rstn),
    .src1    (src1),
    .src2    (src2),
    .sign_en (div_sign),
    .write   (div_done),  // operands still held by upstream at done
    .wr_quo  (div_quo),
    .wr_rem  (div_rem),
    .hit     (cache_hit),
    .hit_quo (hit_quo),
    .hit_rem (hit_rem)
  );

  // a miss ends by hitting the entry that done just wrote
  assign quo_res = div_by_zero ? '1 : div_of_zero ? '0 : hit_quo;
  assign rem_res = div_by_zero ? src1 : div_of_zero ? '0 : hit_rem;

  assign stall = mult_stall | div_miss;

  always_comb begin
    case (alu_op)
      alu_pkg::op_add,
      alu_pkg::op_sub:   result = adder_sum;
      alu_pkg::op_slt:   result = {{(alu_pkg::xlen-1){1'b0}}, slt_bit};
      alu_pkg::op_sltu:  result = {{(alu_pkg::xlen-1){1'b0}}, sltu_bit};
      alu_pkg::op_and:   result = src1 & src2;
      alu_pkg::op_nor:   result = ~(src1 | src2);
      alu_pkg::op_or:    result = src1 | src2;
      alu_pkg::op_xor:   result = src1 ^ src2;
      alu_pkg::op_lui:   result = src2;  // upper bits come pre-shifted
      alu_pkg::op_sll:   result = sll_res;
      alu_pkg::op_srl,
      alu_pkg::op_sra:   result = sr64_res[alu_pkg::xlen-1:0];
      alu_pkg::op_mul:   result = product[alu_pkg::xlen-1:0];
      alu_pkg::op_mulh,
      alu_pkg::op_mulhu: result = product[2*alu_pkg::xlen-1:alu_pkg::xlen];
      alu_pkg::op_div,
      alu_pkg::op_divu:  result = quo_res;
      alu_pkg::op_mod,
      alu_pkg::op_modu:  result = rem_res;
      default:           result = '0;
    endcase
  end

  // a finished divide is served from the cache and never relaunched
  a_no_relaunch: assert property (@(posedge clk) disable iff (!rstn)
    div_inst.state == alu_pkg::div_done |=> !div_start);

  // longest stall is a full divide miss
  a_stall_bound: assert property (@(posedge clk) disable iff (!rstn)
    $rose(stall) |-> ##[1:alu_pkg::div_stall_cycles] !stall);

endmodule

`default_nettype wire

//--- sim/alu_tb_vectors.svh
`ifndef ALU_TB_VECTORS_SVH
`define ALU_TB_VECTORS_SVH

// each row holds opcode, src1, src2, expected result and expected stall cycles
localparam int n_vec = 38;

vec_t vec_table [n_vec] = '{
  '{alu_pkg::op_add,   32'h0000_0005, 32'h0000_0007, 32'h0000_000c, 8'd0},
  '{alu_pkg::op_add,   32'hffff_ffff, 32'h0000_0001, 32'h0000_0000, 8'd0},  // wraps
  '{alu_pkg::op_sub,   32'h0000_0003, 32'h0000_0005, 32'hffff_fffe, 8'd0},
  '{alu_pkg::op_sub,   32'h8000_0000, 32'h0000_0001, 32'h7fff_ffff, 8'd0},
  '{alu_pkg::op_and,   32'hf0f0_ff00, 32'h0ff0_f0f0, 32'h00f0_f000, 8'd0},
  '{alu_pkg::op_nor,   32'hf0f0_ff00, 32'h0ff0_f0f0, 32'h000f_000f, 8'd0},
  '{alu_pkg::op_or,    32'hf0f0_ff00, 32'h0ff0_f0f0, 32'hfff0_fff0, 8'd0},
  '{alu_pkg::op_xor,   32'hf0f0_ff00, 32'h0ff0_f0f0, 32'hff00_0ff0, 8'd0},
  '{alu_pkg::op_lui,   32'h1234_5678, 32'habcd_0000, 32'habcd_0000, 8'd0},
  // slt and sltu disagree on mixed signs
  '{alu_pkg::op_slt,   32'hffff_ffff, 32'h0000_0001, 32'h0000_0001, 8'd0},
  '{alu_pkg::op_sltu,  32'hffff_ffff, 32'h0000_0001, 32'h0000_0000, 8'd0},
  '{alu_pkg::op_slt,   32'h0000_0001, 32'hffff_ffff, 32'h0000_0000, 8'd0},
  '{alu_pkg::op_sltu,  32'h0000_0001, 32'hffff_ffff, 32'h0000_0001, 8'd0},
  '{alu_pkg::op_sll,   32'h0000_0001, 32'h0000_0024, 32'h0000_0010, 8'd0},  // shamt 4
  '{alu_pkg::op_srl,   32'h8000_0000, 32'hffff_ffe4, 32'h0800_0000, 8'd0},
  '{alu_pkg::op_sra,   32'h8000_0000, 32'h0000_0004, 32'hf800_0000, 8'd0},
  '{alu_pkg::op_sra,   32'h8000_0000, 32'h0000_001f, 32'hffff_ffff, 8'd0},
  '{alu_pkg::op_mul,   32'h1234_5678, 32'h0000_0010, 32'h2345_6780, 8'd1},
  '{alu_pkg::op_mulh,  32'hffff_fffe, 32'hffff_fffd, 32'h0000_0000, 8'd1},  // -2 * -3
  '{alu_pkg::op_mul,   32'hffff_fffe, 32'hffff_fffd, 32'h0000_0006, 8'd1},
  '{alu_pkg::op_mulhu, 32'hffff_fffe, 32'hffff_fffd, 32'hffff_fffb, 8'd1},
  '{alu_pkg::op_mulh,  32'h8000_0000, 32'h0000_0002, 32'hffff_ffff, 8'd1},
  // divide history with two round-robin entries
  '{alu_pkg::op_div,   32'hffff_fff9, 32'h0000_0002, 32'hffff_fffd, miss_stall},
  '{alu_pkg::op_mod,   32'hffff_fff9, 32'h0000_0002, 32'hffff_ffff, 8'd0},
  '{alu_pkg::op_divu,  32'hffff_fff9, 32'h0000_0002, 32'h7fff_fffc, miss_stall},
  '{alu_pkg::op_modu,  32'hffff_fff9, 32'h0000_0002, 32'h0000_0001, 8'd0},
  '{alu_pkg::op_div,   32'h8000_0000, 32'hffff_ffff, 32'h8000_0000, miss_stall},
  '{alu_pkg::op_mod,   32'h8000_0000, 32'hffff_ffff, 32'h0000_0000, 8'd0},
  '{alu_pkg::op_div,   32'hffff_fff9, 32'h0000_0002, 32'hffff_fffd, miss_stall},  // evicted
  '{alu_pkg::op_mod,   32'h0000_0007, 32'hffff_fffe, 32'h0000_0001, miss_stall},
  '{alu_pkg::op_div,   32'h0000_0007, 32'hffff_fffe, 32'hffff_fffd, 8'd0},
  '{alu_pkg::op_modu,  32'h0000_0064, 32'h0000_0007, 32'h0000_0002, miss_stall},
  '{alu_pkg::op_divu,  32'h0000_0064, 32'h0000_0007, 32'h0000_000e, 8'd0},
  // zero divisor or zero dividend skips the divider
  '{alu_pkg::op_div,   32'h1234_5678, 32'h0000_0000, 32'hffff_ffff, 8'd0},
  '{alu_pkg::op_mod,   32'h1234_5678, 32'h0000_0000, 32'h1234_5678, 8'd0},
  '{alu_pkg::op_divu,  32'h0000_0000, 32'h0000_0005, 32'h0000_0000, 8'd0},
  '{alu_pkg::op_modu,  32'h0000_0000, 32'h0000_0005, 32'h0000_0000, 8'd0},
  '{alu_pkg::op_mod,   32'h8000_0000, 32'h0000_0000, 32'h8000_0000, 8'd0}
};

`endif

//--- sim/alu_tb.sv
`timescale 1ns/10ps
`default_nettype none

module alu_tb;

  typedef struct packed {
    alu_pkg::alu_op_e op;
    logic [31:0]      a;
    logic [31:0]      b;
    logic [31:0]      exp;
    logic [7:0]       stalls;
  } vec_t;

  localparam logic [7:0] miss_stall = 8'(alu_pkg::div_stall_cycles);
  localparam int n_rand = 40;

  `include "alu_tb_vectors.svh"

  localparam int cycle_limit = (n_vec + n_rand) * 40 + 200;

  logic             clk = 1'b0;
  logic             rstn;
  alu_pkg::alu_op_e alu_op;
  logic [31:0]      src1;
  logic [31:0]      src2;
  logic [31:0]      result;
  logic             stall;
  int               cycle_cnt = 0;

  alu alu_inst (
    .clk    (clk),
    .rstn   (rstn),
    .alu_op (alu_op),
    .src1   (src1),
    .src2   (src2),
    .result (result),
    .stall  (stall)
  );

  always #10 clk = ~clk;

  task automatic stop_with_failure();
    $display("ERRORS FOUND");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic report_mismatch(input string sig, input logic [31:0] got,
                                 input logic [31:0] exp, input int idx);
    $display("FAIL %s got 0x%h expected 0x%h at vector %0d", sig, got, exp, idx);
    stop_with_failure();
  endtask

  // hard limit on the whole run
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("timeout: vectors not finished after %0d cycles", cycle_limit);
      stop_with_failure();
    end
  end

  // behavioral model for the non-divide ops
  function automatic logic [31:0] ref_result(input alu_pkg::alu_op_e op,
                                             input logic [31:0] a, input logic [31:0] b);
    logic [63:0] prod_s;
    logic [63:0] prod_u;
    logic [4:0]  sh;
    prod_s = {{32{a[31]}}, a} * {{32{b[31]}}, b};  // low 64 bits of signed product
    prod_u = {32'b0, a} * {32'b0, b};
    sh     = b[4:0];
    case (op)
      alu_pkg::op_add:   ref_result = a + b;
      alu_pkg::op_sub:   ref_result = a - b;
      alu_pkg::op_slt:   ref_result = {31'b0, $signed(a) < $signed(b)};
      alu_pkg::op_sltu:  ref_result = {31'b0, a < b};
      alu_pkg::op_and:   ref_result = a & b;
      alu_pkg::op_nor:   ref_result = ~(a | b);
      alu_pkg::op_or:    ref_result = a | b;
      alu_pkg::op_xor:   ref_result = a ^ b;
      alu_pkg::op_sll:   ref_result = a << sh;
      alu_pkg::op_srl:   ref_result = a >> sh;
      alu_pkg::op_sra:   ref_result = $unsigned($signed(a) >>> sh);
      alu_pkg::op_lui:   ref_result = b;
      alu_pkg::op_mul:   ref_result = prod_u[31:0];
      alu_pkg::op_mulh:  ref_result = prod_s[63:32];
      alu_pkg::op_mulhu: ref_result = prod_u[63:32];
      default:           ref_result = 32'h0;
    endcase
  endfunction

  // drive one op, count stall cycles, check result once stall drops
  task automatic apply_vector(input vec_t v, input int idx);
    int stall_seen;
    stall_seen = 0;
    @(posedge clk);
    alu_op <= v.op;
    src1   <= v.a;
    src2   <= v.b;
    @(negedge clk);
    while (stall) begin
      stall_seen++;
      @(negedge clk);
    end
    assert (result == v.exp)
      else report_mismatch("result", result, v.exp, idx);
    assert (stall_seen == int'(v.stalls))
      else report_mismatch("stall_cycles", 32'(stall_seen), 32'(v.stalls), idx);
  endtask

  initial begin
    vec_t rv;
    rstn   = 1'b0;
    alu_op = alu_pkg::op_add;
    src1   = '0;
    src2   = '0;
    void'($urandom(53751));
    repeat (8) @(posedge clk);
    rstn <= 1'b1;

    for (int i = 0; i < n_vec; i++) begin
      apply_vector(vec_table[i], i);
    end

    // random ops up to mulhu skip the divider
    for (int i = 0; i < n_rand; i++) begin
      rv.op     = alu_pkg::alu_op_e'($urandom_range(int'(alu_pkg::op_mulhu), 0));
      rv.a      = $urandom();
      rv.b      = $urandom();
      rv.exp    = ref_result(rv.op, rv.a, rv.b);
      rv.stalls = (rv.op inside {alu_pkg::op_mul, alu_pkg::op_mulh, alu_pkg::op_mulhu})
                  ? 8'd1 : 8'd0;
      apply_vector(rv, n_vec + i);
    end

    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

//--- exec_alu.f
+incdir+sim
verilog/alu_pkg.sv
verilog/mult_core.sv
verilog/div_core.sv
verilog/div_result_cache.sv
verilog/alu.sv
sim/alu_tb.sv

//--- Bender.yml
package:
  name: exec_alu

sources:
  - files:
      - verilog/alu_pkg.sv
      - verilog/mult_core.sv
      - verilog/div_core.sv
      - verilog/div_result_cache.sv
      - verilog/alu.sv
  - target: test
    include_dirs:
      - sim
    files:
      - sim/alu_tb.sv
